// ==== hdl/engine_pkg.sv ====
// Engine pipeline shared types

`default_nettype none

package engine_pkg;

    // ------------------------------------------------------------
    // Payload widths
    // ------------------------------------------------------------
    localparam int VERTEX_ID_W    = 32;
    localparam int VERTEX_VALUE_W = 32;

    typedef logic [VERTEX_ID_W-1:0]    vertex_id_t;
    typedef logic [VERTEX_VALUE_W-1:0] vertex_value_t;

    // Vertex id in the upper half, value in the lower half
    typedef logic [$bits(vertex_id_t)+$bits(vertex_value_t)-1:0] engine_payload_t;

    // ------------------------------------------------------------
    // Packet and FIFO handshake structs
    // ------------------------------------------------------------
    typedef struct packed {
        logic            valid;
        engine_payload_t payload;
    } engine_packet_t;

    // Pop request from the consumer side
    typedef struct packed {
        logic rd_en;
    } fifo_ctrl_t;

    // State word reported for each FIFO
    typedef struct packed {
        logic empty;
        logic prog_full;
    } fifo_state_t;

    // ------------------------------------------------------------
    // Status FSM
    // ------------------------------------------------------------
    typedef enum logic {
        STATUS_SETUP,
        STATUS_RUN
    } status_state_e;

    // Cycles of setup after reset is released
    localparam int SETUP_CYCLES = 4;

endpackage : engine_pkg

`default_nettype wire

// ==== hdl/engine_sync_fifo.sv ====
// Synchronous packet FIFO

`default_nettype none

module engine_sync_fifo
    import engine_pkg::*;
#(
    parameter int DEPTH  = 16,
    parameter int THRESH = 8
) (
    input  logic            ap_clk,
    input  logic            areset_template_engine,
    input  engine_payload_t din,
    input  logic            wr_en,
    input  logic            rd_en,
    output engine_payload_t dout,
    output logic            valid,
    output logic            empty,
    output logic            full,
    output logic            prog_full
);

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);

    typedef logic [ADDR_W-1:0] fifo_addr_t;
    typedef logic [CNT_W-1:0]  fifo_count_t;

    engine_payload_t mem [DEPTH];

    fifo_addr_t  wr_ptr_q;
    fifo_addr_t  rd_ptr_q;
    fifo_count_t count_q;

    logic wr_fire;
    logic rd_fire;

    // Wrap at DEPTH so non power of two depths also work
    function automatic fifo_addr_t next_ptr(fifo_addr_t ptr);
        fifo_addr_t nxt;
        if (ptr == fifo_addr_t'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // ------------------------------------------------------------
    // Flags from occupancy
    // ------------------------------------------------------------
    assign empty     = (count_q == '0);
    assign full      = (count_q == fifo_count_t'(DEPTH));
    assign prog_full = (count_q >= fifo_count_t'(THRESH));

    // Write into full and read from empty are dropped
    assign wr_fire = wr_en & ~full;
    assign rd_fire = rd_en & ~empty;

    // ------------------------------------------------------------
    // Pointers and count
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            valid    <= 1'b0;
        end else begin
            if (wr_fire) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (rd_fire) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({wr_fire, rd_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            valid <= rd_fire;
        end
    end

    // Storage and registered read data
    always_ff @(posedge ap_clk) begin
        if (wr_fire) begin
            mem[wr_ptr_q] <= din;
        end
        if (rd_fire) begin
            dout <= mem[rd_ptr_q];
        end
    end

endmodule : engine_sync_fifo

`default_nettype wire

// ==== hdl/engine_hyper_pipeline.sv ====
// Engine packet register pipeline

`default_nettype none

module engine_hyper_pipeline
    import engine_pkg::*;
#(
    parameter int STAGES = 2
) (
    input  logic           ap_clk,
    input  logic           areset_template_engine,
    input  engine_packet_t din,
    output engine_packet_t dout,
    output logic           busy
);

    logic [STAGES-1:0] valid_q;
    engine_payload_t   payload_q [STAGES];

    // Valid chain, cleared on reset
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= din.valid;
            for (int i = 1; i < STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload chain
    always_ff @(posedge ap_clk) begin
        payload_q[0] <= din.payload;
        for (int i = 1; i < STAGES; i++) begin
            payload_q[i] <= payload_q[i-1];
        end
    end

    assign dout.valid   = valid_q[STAGES-1];
    assign dout.payload = payload_q[STAGES-1];

    // Any packet in flight
    assign busy = |valid_q;

endmodule : engine_hyper_pipeline

`default_nettype wire

// ==== hdl/engine_ingress.sv ====
// Engine response ingress

`default_nettype none

module engine_ingress
    import engine_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic           ap_clk,
    input  logic           areset_template_engine,
    input  engine_packet_t response_engine_in,
    input  fifo_ctrl_t     fifo_ctrl,
    input  logic           downstream_prog_full,
    output engine_packet_t packet_out,
    output fifo_state_t    fifo_state,
    output logic           fifo_empty
);

    engine_packet_t  in_q;
    fifo_ctrl_t      ctrl_q;
    engine_payload_t fifo_dout;
    logic            fifo_valid;
    logic            fifo_rd_en;
    logic            fifo_empty_int;
    logic            fifo_prog_full;

    // ------------------------------------------------------------
    // Input registers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            in_q.valid <= 1'b0;
            ctrl_q     <= '0;
        end else begin
            in_q.valid <= response_engine_in.valid;
            ctrl_q     <= fifo_ctrl;
        end
    end

    always_ff @(posedge ap_clk) begin
        in_q.payload <= response_engine_in.payload;
    end

    // ------------------------------------------------------------
    // Input FIFO
    // ------------------------------------------------------------
    // Pop only while the output side has room
    assign fifo_rd_en = ~fifo_empty_int & ctrl_q.rd_en & ~downstream_prog_full;

    engine_sync_fifo #(
        .DEPTH (FIFO_DEPTH),
        .THRESH(PROG_THRESH)
    ) i_fifo (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .din                   (in_q.payload),
        .wr_en                 (in_q.valid),
        .rd_en                 (fifo_rd_en),
        .dout                  (fifo_dout),
        .valid                 (fifo_valid),
        .empty                 (fifo_empty_int),
        .full                  (),
        .prog_full             (fifo_prog_full)
    );

    assign packet_out.valid   = fifo_valid;
    assign packet_out.payload = fifo_dout;

    // Nothing in the input register, the FIFO or its read register
    assign fifo_empty = fifo_empty_int & ~in_q.valid & ~fifo_valid;

    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            fifo_state <= '{empty: 1'b1, prog_full: 1'b0};
        end else begin
            fifo_state <= '{empty: fifo_empty_int, prog_full: fifo_prog_full};
        end
    end

endmodule : engine_ingress

`default_nettype wire

// ==== hdl/engine_egress.sv ====
// Engine request egress

`default_nettype none

module engine_egress
    import engine_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic           ap_clk,
    input  logic           areset_template_engine,
    input  engine_packet_t packet_in,
    input  fifo_ctrl_t     fifo_ctrl,
    output engine_packet_t request_engine_out,
    output fifo_state_t    fifo_state,
    output logic           fifo_empty,
    output logic           prog_full
);

    fifo_ctrl_t      ctrl_q;
    engine_payload_t fifo_dout;
    logic            fifo_valid;
    logic            fifo_rd_en;
    logic            fifo_empty_int;
    logic            fifo_prog_full;

    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= fifo_ctrl;
        end
    end

    // ------------------------------------------------------------
    // Output FIFO
    // ------------------------------------------------------------
    assign fifo_rd_en = ~fifo_empty_int & ctrl_q.rd_en;

    engine_sync_fifo #(
        .DEPTH (FIFO_DEPTH),
        .THRESH(PROG_THRESH)
    ) i_fifo (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .din                   (packet_in.payload),
        .wr_en                 (packet_in.valid),
        .rd_en                 (fifo_rd_en),
        .dout                  (fifo_dout),
        .valid                 (fifo_valid),
        .empty                 (fifo_empty_int),
        .full                  (),
        .prog_full             (fifo_prog_full)
    );

    // Back-pressure toward ingress without delay
    assign prog_full = fifo_prog_full;

    // ------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            request_engine_out.valid <= 1'b0;
            fifo_state               <= '{empty: 1'b1, prog_full: 1'b0};
        end else begin
            request_engine_out.valid <= fifo_valid;
            fifo_state               <= '{empty: fifo_empty_int, prog_full: fifo_prog_full};
        end
    end

    always_ff @(posedge ap_clk) begin
        request_engine_out.payload <= fifo_dout;
    end

    // Idle once the FIFO, read register and output register are clear
    assign fifo_empty = fifo_empty_int & ~fifo_valid & ~request_engine_out.valid;

endmodule : engine_egress

`default_nettype wire

// ==== hdl/engine_status.sv ====
// Engine setup and done status

`default_nettype none

module engine_status
    import engine_pkg::*;
(
    input  logic ap_clk,
    input  logic areset_template_engine,
    input  logic ingress_empty,
    input  logic egress_empty,
    input  logic pipeline_busy,
    output logic fifo_setup_signal,
    output logic done_out
);

    localparam int CNT_W = $clog2(SETUP_CYCLES + 1);

    status_state_e    state_q;
    logic [CNT_W-1:0] setup_cnt_q;
    logic             idle;

    // ------------------------------------------------------------
    // Setup FSM
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            state_q     <= STATUS_SETUP;
            setup_cnt_q <= '0;
        end else begin
            case (state_q)
                STATUS_SETUP: begin
                    setup_cnt_q <= setup_cnt_q + 1'b1;
                    if (setup_cnt_q == CNT_W'(SETUP_CYCLES - 1)) begin
                        state_q <= STATUS_RUN;
                    end
                end
                default: begin
                    state_q <= STATUS_RUN;
                end
            endcase
        end
    end

    assign fifo_setup_signal = (state_q == STATUS_SETUP);

    // No packet held in either FIFO path or the pipeline
    assign idle = ingress_empty & egress_empty & ~pipeline_busy;

    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            done_out <= 1'b0;
        end else begin
            done_out <= (state_q == STATUS_RUN) & idle;
        end
    end

endmodule : engine_status

`default_nettype wire

// ==== hdl/engine_pipeline.sv ====
// Engine pipeline top level

`default_nettype none

module engine_pipeline
    import engine_pkg::*;
#(
    parameter int FIFO_DEPTH      = 16,
    parameter int PROG_THRESH     = 8,
    parameter int PIPELINE_STAGES = 2
) (
    input  logic           ap_clk,
    input  logic           areset_template_engine,
    input  engine_packet_t response_engine_in,
    input  fifo_ctrl_t     fifo_response_engine_in_signals_in,
    output fifo_state_t    fifo_response_engine_in_signals_out,
    output engine_packet_t request_engine_out,
    input  fifo_ctrl_t     fifo_request_engine_out_signals_in,
    output fifo_state_t    fifo_request_engine_out_signals_out,
    output logic           fifo_setup_signal,
    output logic           done_out
);

    // ------------------------------------------------------------
    // Internal wires
    // ------------------------------------------------------------
    engine_packet_t ingress_packet;
    engine_packet_t pipeline_packet;
    logic           egress_prog_full;
    logic           ingress_empty;
    logic           egress_empty;
    logic           pipeline_busy;

    // Response input FIFO
    engine_ingress #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) i_ingress (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .response_engine_in    (response_engine_in),
        .fifo_ctrl             (fifo_response_engine_in_signals_in),
        .downstream_prog_full  (egress_prog_full),
        .packet_out            (ingress_packet),
        .fifo_state            (fifo_response_engine_in_signals_out),
        .fifo_empty            (ingress_empty)
    );

    // Fixed latency engine stages
    engine_hyper_pipeline #(
        .STAGES(PIPELINE_STAGES)
    ) i_hyper_pipeline (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .din                   (ingress_packet),
        .dout                  (pipeline_packet),
        .busy                  (pipeline_busy)
    );

    // Request output FIFO
    engine_egress #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) i_egress (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .packet_in             (pipeline_packet),
        .fifo_ctrl             (fifo_request_engine_out_signals_in),
        .request_engine_out    (request_engine_out),
        .fifo_state            (fifo_request_engine_out_signals_out),
        .fifo_empty            (egress_empty),
        .prog_full             (egress_prog_full)
    );

    // ------------------------------------------------------------
    // Setup and done flags
    // ------------------------------------------------------------
    engine_status i_status (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .ingress_empty         (ingress_empty),
        .egress_empty          (egress_empty),
        .pipeline_busy         (pipeline_busy),
        .fifo_setup_signal     (fifo_setup_signal),
        .done_out              (done_out)
    );

endmodule : engine_pipeline

`default_nettype wire

// ==== verif/tb_engine_pipeline.sv ====
// Engine pipeline testbench

`default_nettype none

module tb_engine_pipeline
    import engine_pkg::*;
;

    localparam int          FIFO_DEPTH      = 16;
    localparam int          PROG_THRESH     = 8;
    localparam int          PIPELINE_STAGES = 2;
    localparam int          WAIT_LIMIT      = 2000;
    localparam int          STIM_COUNT      = 35;
    localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;

    typedef struct packed {
        vertex_id_t    id;
        vertex_value_t value;
        logic          in_rd;
        logic          out_rd;
        logic [3:0]    gap;
    } stim_t;

    // Free flow, then output held, then input held
    localparam stim_t STIM_TABLE [STIM_COUNT] = '{
        '{32'h01, 32'hc0de_0001, 1'b1, 1'b1, 4'd0}, '{32'h02, 32'hc0de_0002, 1'b1, 1'b1, 4'd1},
        '{32'h03, 32'hc0de_0003, 1'b1, 1'b1, 4'd0}, '{32'h04, 32'hc0de_0004, 1'b1, 1'b1, 4'd2},
        '{32'h05, 32'hc0de_0005, 1'b1, 1'b1, 4'd0}, '{32'h06, 32'hc0de_0006, 1'b1, 1'b1, 4'd0},
        '{32'h07, 32'hc0de_0007, 1'b1, 1'b1, 4'd3}, '{32'h08, 32'hc0de_0008, 1'b1, 1'b1, 4'd1},
        '{32'h20, 32'h5eed_0020, 1'b1, 1'b0, 4'd0}, '{32'h21, 32'h5eed_0021, 1'b1, 1'b0, 4'd0},
        '{32'h22, 32'h5eed_0022, 1'b1, 1'b0, 4'd0}, '{32'h23, 32'h5eed_0023, 1'b1, 1'b0, 4'd0},
        '{32'h24, 32'h5eed_0024, 1'b1, 1'b0, 4'd0}, '{32'h25, 32'h5eed_0025, 1'b1, 1'b0, 4'd0},
        '{32'h26, 32'h5eed_0026, 1'b1, 1'b0, 4'd0}, '{32'h27, 32'h5eed_0027, 1'b1, 1'b0, 4'd0},
        '{32'h28, 32'h5eed_0028, 1'b1, 1'b0, 4'd0}, '{32'h29, 32'h5eed_0029, 1'b1, 1'b0, 4'd0},
        '{32'h2a, 32'h5eed_002a, 1'b1, 1'b0, 4'd0}, '{32'h2b, 32'h5eed_002b, 1'b1, 1'b0, 4'd0},
        '{32'h2c, 32'h5eed_002c, 1'b1, 1'b0, 4'd0}, '{32'h2d, 32'h5eed_002d, 1'b1, 1'b0, 4'd0},
        '{32'h2e, 32'h5eed_002e, 1'b1, 1'b0, 4'd0}, '{32'h2f, 32'h5eed_002f, 1'b1, 1'b0, 4'd0},
        '{32'h30, 32'h5eed_0030, 1'b1, 1'b0, 4'd0}, '{32'h31, 32'h5eed_0031, 1'b1, 1'b0, 4'd0},
        '{32'h32, 32'h5eed_0032, 1'b1, 1'b0, 4'd0}, '{32'h33, 32'h5eed_0033, 1'b1, 1'b0, 4'd0},
        '{32'h34, 32'h5eed_0034, 1'b1, 1'b0, 4'd0}, '{32'h40, 32'hf00d_0040, 1'b0, 1'b1, 4'd1},
        '{32'h41, 32'hf00d_0041, 1'b0, 1'b1, 4'd1}, '{32'h42, 32'hf00d_0042, 1'b0, 1'b1, 4'd1},
        '{32'h43, 32'hf00d_0043, 1'b0, 1'b1, 4'd1}, '{32'h44, 32'hf00d_0044, 1'b0, 1'b1, 4'd1},
        '{32'h45, 32'hf00d_0045, 1'b0, 1'b1, 4'd1}
    };

    logic           ap_clk;
    logic           areset_template_engine;
    engine_packet_t response_engine_in;
    fifo_ctrl_t     in_ctrl;
    fifo_ctrl_t     out_ctrl;
    fifo_state_t    in_state;
    fifo_state_t    out_state;
    engine_packet_t request_engine_out;
    logic           fifo_setup_signal;
    logic           done_out;

    logic [31:0]     lfsr_q;
    engine_payload_t expected_q [$];
    logic            hold_output;
    logic            released;
    logic            out_full_seen;
    logic            done_low_seen;
    time             last_push_time;

    engine_pipeline #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .PROG_THRESH    (PROG_THRESH),
        .PIPELINE_STAGES(PIPELINE_STAGES)
    ) i_dut (
        .ap_clk                             (ap_clk),
        .areset_template_engine             (areset_template_engine),
        .response_engine_in                 (response_engine_in),
        .fifo_response_engine_in_signals_in (in_ctrl),
        .fifo_response_engine_in_signals_out(in_state),
        .request_engine_out                 (request_engine_out),
        .fifo_request_engine_out_signals_in (out_ctrl),
        .fifo_request_engine_out_signals_out(out_state),
        .fifo_setup_signal                  (fifo_setup_signal),
        .done_out                           (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------
    // Reporting and random gaps
    // ------------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("Error %s expected %h got %h", name, expected, actual));
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic int next_random_bits(input int count);
        int   bits;
        logic lsb;
        bits = 0;
        for (int i = 0; i < count; i++) begin
            lsb    = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (lsb) begin
                lfsr_q = lfsr_q ^ LFSR_TAPS;
            end
            bits = (bits << 1) | int'(lsb);
        end
        return bits;
    endfunction

    task automatic check_reset_outputs();
        check_value("request_engine_out.valid", 64'h0, request_engine_out.valid);
        check_value("done_out", 64'h0, done_out);
        check_value("fifo_setup_signal", 64'h1, fifo_setup_signal);
        check_value("fifo_response_engine_in_signals_out", 64'h2, in_state);
        check_value("fifo_request_engine_out_signals_out", 64'h2, out_state);
    endtask

    // ------------------------------------------------------------
    // Scoreboard and flag monitor
    // ------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (!areset_template_engine) begin
            if (request_engine_out.valid) begin
                if (hold_output) begin
                    report_failure("a packet was delivered while a read enable was held low");
                end else if (expected_q.size() == 0) begin
                    report_failure("a packet was delivered with no packet pending");
                end else begin
                    check_value("request_engine_out.payload", expected_q[0],
                                request_engine_out.payload);
                    void'(expected_q.pop_front());
                end
            end
            // done may lag a fresh push by two cycles
            if (done_out && expected_q.size() != 0 && ($time - last_push_time) > 150) begin
                report_failure("done_out was high while packets were still pending");
            end
            if (!done_out && expected_q.size() != 0) begin
                done_low_seen = 1'b1;
            end
            if (out_state.prog_full) begin
                out_full_seen = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic release_reads();
        if (!out_ctrl.rd_en) begin
            check_value("out_full_seen", 64'h1, out_full_seen);
        end
        hold_output    = 1'b0;
        released       = 1'b1;
        in_ctrl.rd_en  = 1'b1;
        out_ctrl.rd_en = 1'b1;
    endtask

    task automatic send_entry(input stim_t e);
        int extra;
        int waited;
        waited         = 0;
        in_ctrl.rd_en  = e.in_rd;
        out_ctrl.rd_en = e.out_rd | released;
        hold_output    = ~(e.in_rd & (e.out_rd | released));
        // Producer pauses on input prog_full
        while (in_state.prog_full) begin
            if (!out_ctrl.rd_en) begin
                release_reads();
            end
            @(negedge ap_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("timeout waiting for input prog_full to fall");
            end
        end
        response_engine_in.valid   = 1'b1;
        response_engine_in.payload = {e.id, e.value};
        last_push_time             = $time;
        expected_q.push_back({e.id, e.value});
        @(negedge ap_clk);
        response_engine_in.valid = 1'b0;
        extra = next_random_bits(2);
        repeat (e.gap + extra) @(negedge ap_clk);
    endtask

    task automatic finish_group();
        int waited;
        waited = 0;
        if (!released && !out_ctrl.rd_en) begin
            while (!in_state.prog_full) begin
                @(negedge ap_clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_failure("timeout waiting for input prog_full under back-pressure");
                end
            end
            release_reads();
        end else if (!released && !in_ctrl.rd_en) begin
            while (in_state.empty) begin
                @(negedge ap_clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_failure("timeout waiting for the input FIFO to leave empty");
                end
            end
            release_reads();
        end
        waited = 0;
        while (expected_q.size() != 0 || !done_out) begin
            @(negedge ap_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("timeout waiting for all packets and done_out");
            end
        end
        released      = 1'b0;
        out_full_seen = 1'b0;
    endtask

    initial begin
        int waited;
        areset_template_engine = 1'b1;
        response_engine_in     = '0;
        in_ctrl                = '0;
        out_ctrl               = '0;
        lfsr_q                 = 32'hadba;
        hold_output            = 1'b0;
        released               = 1'b0;
        out_full_seen          = 1'b0;
        done_low_seen          = 1'b0;
        last_push_time         = 0;
        repeat (10) begin
            @(negedge ap_clk);
            check_reset_outputs();
        end
        areset_template_engine = 1'b0;
        @(negedge ap_clk);
        check_reset_outputs();

        waited = 0;
        while (fifo_setup_signal || !done_out) begin
            @(negedge ap_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("timeout waiting for setup to fall and done_out to rise");
            end
        end

        for (int i = 0; i < STIM_COUNT; i++) begin
            if (i > 0 && (STIM_TABLE[i].in_rd != STIM_TABLE[i-1].in_rd ||
                          STIM_TABLE[i].out_rd != STIM_TABLE[i-1].out_rd)) begin
                finish_group();
            end
            send_entry(STIM_TABLE[i]);
        end
        finish_group();

        check_value("done_low_seen", 64'h1, done_low_seen);
        $display("sim passed");
        $finish;
    end

endmodule : tb_engine_pipeline

`default_nettype wire

// ==== project.f ====
hdl/engine_pkg.sv
hdl/engine_sync_fifo.sv
hdl/engine_hyper_pipeline.sv
hdl/engine_ingress.sv
hdl/engine_egress.sv
hdl/engine_status.sv
hdl/engine_pipeline.sv
verif/tb_engine_pipeline.sv

// ==== Bender.yml ====
package:
  name: engine_pipeline

sources:
  - hdl/engine_pkg.sv
  - hdl/engine_sync_fifo.sv
  - hdl/engine_hyper_pipeline.sv
  - hdl/engine_ingress.sv
  - hdl/engine_egress.sv
  - hdl/engine_status.sv
  - hdl/engine_pipeline.sv
  - target: simulation
    files:
      - verif/tb_engine_pipeline.sv
